// ==== src.f ====
+incdir+.
dino_pkg.sv
game_fsm.sv
run_pacer.sv
dino_physics.sv
obstacle_field.sv
hit_detect.sv
dino_top.sv
dino_assert.sv
tb_clock.sv
tb_dino.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the dino game testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -Wno-fatal \
    --top-module tb_dino -f src.f > build.log 2>&1 &&
    ./obj_dir/Vtb_dino +verilator+error+limit+100000 > sim.log 2>&1 &&
    ! grep -q "TEST RESULT: FAIL" sim.log &&
    grep -q "TEST RESULT: PASS" sim.log &&
    echo "Simulation passed" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// ==== tb_dino.sv ====
`timescale 1ns/1ns
`include "dino_consts.svh"

module tb_dino;
    import dino_pkg::*;

    localparam int WAIT_LIMIT = 4000;
    localparam int AIRBORNE   = 4;      // Wait codes above the state values
    localparam int STANDING   = 5;
    localparam int DUCKED     = 6;
    localparam int MOVED      = 7;
    localparam int OUT_OF_RST = 8;
    localparam logic [`Y_W-1:0] STAND_Y = `Y_W'(`GROUND_Y - `DINO_H);

    logic                   pclk, rst;
    logic                   start_pulse, pause_pulse, jump_btn, duck_btn, vsync;
    logic [19:0]            distance;
    game_state_t            game_state;
    logic [`Y_W-1:0]        dino_y;
    logic                   ducking, collision;
    logic signed [`X_W-1:0] obs_x [0:2];
    obs_kind_t              obs_kind [0:2];
    logic [2:0]             obs_active;
    logic [`SCORE_W-1:0]    score;
    logic signed [`X_W-1:0] x_mark;
    integer                 seed;
    int                     timeouts, tests, failed_tests, err_mark;

    tb_clock u_clock (.pclk(pclk), .rst(rst));

    dino_top DUT (
        .pclk(pclk), .rst(rst), .start_pulse(start_pulse), .pause_pulse(pause_pulse),
        .jump_btn(jump_btn), .duck_btn(duck_btn), .vsync(vsync), .distance(distance),
        .game_state(game_state), .dino_y(dino_y), .ducking(ducking), .obs_x(obs_x),
        .obs_kind(obs_kind), .obs_active(obs_active), .score(score), .collision(collision)
    );

    // Slow vsync, one frame every six clocks
    always begin
        repeat (3) @(negedge pclk);
        vsync = ~vsync;
    end

    function automatic bit reached(input int what);
        case (what)
            0, 1, 2, 3: return game_state == game_state_t'(what);
            AIRBORNE:   return dino_y < STAND_Y;
            STANDING:   return dino_y == STAND_Y && !ducking;
            DUCKED:     return ducking;
            MOVED:      return obs_x[0] != x_mark;
            default:    return !rst;
        endcase
    endfunction

    task automatic wait_until(input int what, input string label);
        int n;
        n = 0;
        while (!reached(what) && n < WAIT_LIMIT) begin
            @(negedge pclk);
            n++;
        end
        if (!reached(what)) begin
            $display("Timeout at %0t: %s never happened", $time, label);
            timeouts++;
        end
    endtask

    task automatic pulse(input bit is_pause);
        @(negedge pclk);
        if (is_pause) begin
            pause_pulse = 1'b1;
        end else begin
            start_pulse = 1'b1;
        end
        @(negedge pclk);
        pause_pulse = 1'b0;
        start_pulse = 1'b0;
    endtask

    task automatic random_delay;
        repeat ($unsigned($random(seed)) % 5) @(negedge pclk);
    endtask

    task automatic end_test(input string name);
        int errs;
        @(negedge pclk);
        errs = DUT.u_assert.fails + timeouts - err_mark;
        tests++;
        if (errs != 0) begin
            failed_tests++;
        end
        $display("Test %0d %s: %0d errors", tests, name, errs);
        err_mark = DUT.u_assert.fails + timeouts;
    endtask

    initial begin
        seed        = 32'h2b99_b767;
        start_pulse = 1'b0;
        pause_pulse = 1'b0;
        jump_btn    = 1'b0;
        duck_btn    = 1'b0;
        vsync       = 1'b0;
        distance    = '0;
        x_mark      = '0;
        timeouts    = 0;
        tests       = 0;
        failed_tests = 0;
        err_mark    = 0;
        wait_until(OUT_OF_RST, "reset release");
        repeat (5) @(negedge pclk);     // Idle hold window

        pulse(1'b0);
        wait_until(st_run, "run after start");
        end_test("start");

        pulse(1'b1);
        wait_until(st_pause, "pause");
        repeat (10) @(negedge pclk);
        pulse(1'b1);
        wait_until(st_run, "resume");
        end_test("pause");

        random_delay();
        jump_btn = 1'b1;
        wait_until(AIRBORNE, "button jump");
        jump_btn = 1'b0;
        wait_until(STANDING, "landing after button jump");
        random_delay();
        distance = 20'(21 + ($unsigned($random(seed)) % 29));
        wait_until(AIRBORNE, "sensor jump");
        distance = '0;
        wait_until(STANDING, "landing after sensor jump");
        end_test("jump");

        random_delay();
        duck_btn = 1'b1;
        wait_until(DUCKED, "button duck");
        duck_btn = 1'b0;
        wait_until(STANDING, "stand after button duck");
        distance = 20'(1 + ($unsigned($random(seed)) % 9));
        wait_until(DUCKED, "sensor duck");
        distance = '0;
        wait_until(STANDING, "stand after sensor duck");
        end_test("duck");

        for (int i = 0; i < 4; i++) begin
            x_mark = obs_x[0];
            wait_until(MOVED, "obstacle step");
        end
        end_test("movement");

        wait_until(st_over, "game over on collision");  // Standing dinosaur meets the cactus
        repeat (3) @(negedge pclk);
        pulse(1'b0);
        wait_until(st_idle, "idle after restart");
        repeat (5) @(negedge pclk);
        end_test("collision and restart");

        $display("Summary: %0d tests, %0d failed, %0d assertion errors, %0d timeouts",
                 tests, failed_tests, DUT.u_assert.fails, timeouts);
        if (failed_tests == 0 && DUT.u_assert.fails == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/1ns

module tb_clock (
    output logic pclk,
    output logic rst
);

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;   // 100 ns period
    end

    // Four rising edges in reset, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(negedge pclk);
        rst = 1'b0;
    end

endmodule

// ==== dino_assert.sv ====
`timescale 1ns/1ns
`include "dino_consts.svh"

module dino_assert (
    input  logic                    pclk,
    input  logic                    rst,
    input  logic                    start_pulse,
    input  logic                    pause_pulse,
    input  logic                    jump_btn,
    input  logic                    duck_btn,
    input  logic [19:0]             distance,
    input  logic                    frame_tick,
    input  dino_pkg::game_state_t   game_state,
    input  logic [`Y_W-1:0]         dino_y,
    input  logic                    ducking,
    input  logic signed [`X_W-1:0]  obs_x [0:2],
    input  dino_pkg::obs_kind_t     obs_kind [0:2],
    input  logic [2:0]              obs_active,
    input  logic [`SCORE_W-1:0]     score,
    input  logic                    collision
);
    import dino_pkg::*;

    localparam logic [`Y_W-1:0]        STAND_Y = `Y_W'(`GROUND_Y - `DINO_H);
    localparam logic [`Y_W-1:0]        DUCK_Y  = `Y_W'(`GROUND_Y - `DINO_DUCK_H);
    localparam logic signed [`X_W-1:0] X_LIMIT = `X_W'(`RETIRE_X);

    int   fails = 0;    // Read by the testbench top
    logic jump_req;
    logic duck_req;

    // Button or hand over the sensor, bounds exclusive
    assign jump_req = jump_btn ||
                      (distance > 20'(`SENSE_JUMP_MIN) && distance < 20'(`SENSE_JUMP_MAX));
    assign duck_req = duck_btn || (distance > 20'd0 && distance < 20'(`SENSE_DUCK_MAX));

    a_start: assert property (@(posedge pclk) disable iff (rst)
        game_state == st_idle && start_pulse |=> game_state == st_run)
        else begin fails++; $error("Mismatch at %0t: start did not enter run", $time); end

    a_hold: assert property (@(posedge pclk) disable iff (rst)
        game_state == st_idle || game_state == st_pause |=>
        $stable(dino_y) && $stable(obs_x[0]) && $stable(obs_x[1]) && $stable(obs_x[2]))
        else begin fails++; $error("Mismatch at %0t: position moved while halted", $time); end

    a_pause: assert property (@(posedge pclk) disable iff (rst)
        game_state == st_run && !collision && pause_pulse |=> game_state == st_pause)
        else begin fails++; $error("Mismatch at %0t: pause not taken", $time); end

    a_resume: assert property (@(posedge pclk) disable iff (rst)
        game_state == st_pause && pause_pulse |=> game_state == st_run)
        else begin fails++; $error("Mismatch at %0t: resume not taken", $time); end

    a_jump: assert property (@(posedge pclk) disable iff (rst)
        frame_tick && dino_y == STAND_Y && jump_req |=> dino_y == STAND_Y - `Y_W'(`JUMP_VEL))
        else begin fails++; $error("Mismatch at %0t: jump start y is %0d", $time, dino_y); end

    a_air: assert property (@(posedge pclk) disable iff (rst)
        frame_tick && dino_y < STAND_Y |=> dino_y <= STAND_Y)
        else begin fails++; $error("Mismatch at %0t: landed below ground, y %0d", $time, dino_y); end

    a_duck: assert property (@(posedge pclk) disable iff (rst)
        frame_tick && dino_y >= STAND_Y && !jump_req && duck_req |=> dino_y == DUCK_Y && ducking)
        else begin fails++; $error("Mismatch at %0t: duck gave y %0d", $time, dino_y); end

    // Each slot steps left by base speed plus score over 16
    for (genvar i = 0; i < 3; i++) begin : g_move
        a_move: assert property (@(posedge pclk) disable iff (rst)
            frame_tick && obs_active[i] && obs_x[i] >= X_LIMIT |=>
            obs_x[i] == $past(obs_x[i]) - `X_W'(`BASE_SPEED + ($past(score) >> 4)))
            else begin fails++; $error("Mismatch at %0t: slot %0d x %0d", $time, i, obs_x[i]); end
    end

    a_hit: assert property (@(posedge pclk) disable iff (rst)
        game_state == st_run && collision |=> game_state == st_over)
        else begin fails++; $error("Mismatch at %0t: collision did not end run", $time); end

    a_restart: assert property (@(posedge pclk) disable iff (rst)
        game_state == st_over && start_pulse |=> game_state == st_idle && dino_y == STAND_Y &&
        obs_active[0] && obs_x[0] == `X_W'(`FIRST_X) && obs_kind[0] == 2'd0 &&
        score == '0)
        else begin fails++; $error("Mismatch at %0t: restart values wrong", $time); end

endmodule

bind dino_top dino_assert u_assert (
    .pclk        (pclk),
    .rst         (rst),
    .start_pulse (start_pulse),
    .pause_pulse (pause_pulse),
    .jump_btn    (jump_btn),
    .duck_btn    (duck_btn),
    .distance    (distance),
    .frame_tick  (frame_tick),
    .game_state  (game_state),
    .dino_y      (dino_y),
    .ducking     (ducking),
    .obs_x       (obs_x),
    .obs_kind    (obs_kind),
    .obs_active  (obs_active),
    .score       (score),
    .collision   (collision)
);

// ==== dino_top.sv ====
`timescale 1ns/1ns
`include "dino_consts.svh"

module dino_top (
    input  logic                    pclk,
    input  logic                    rst,
    input  logic                    start_pulse,
    input  logic                    pause_pulse,
    input  logic                    jump_btn,
    input  logic                    duck_btn,
    input  logic                    vsync,
    input  logic [19:0]             distance,
    output dino_pkg::game_state_t   game_state,
    output logic [`Y_W-1:0]         dino_y,
    output logic                    ducking,
    output logic signed [`X_W-1:0]  obs_x [0:2],
    output dino_pkg::obs_kind_t     obs_kind [0:2],
    output logic [2:0]              obs_active,
    output logic [`SCORE_W-1:0]     score,
    output logic                    collision
);

    logic       frame_tick;
    logic [6:0] speed;
    logic       retire;     // Obstacle left the screen

    game_fsm u_fsm (
        .pclk        (pclk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .pause_pulse (pause_pulse),
        .collision   (collision),
        .game_state  (game_state)
    );

    run_pacer u_pacer (
        .pclk        (pclk),
        .rst         (rst),
        .vsync       (vsync),
        .start_pulse (start_pulse),
        .retire      (retire),
        .game_state  (game_state),
        .frame_tick  (frame_tick),
        .score       (score),
        .speed       (speed)
    );

    dino_physics u_physics (
        .pclk        (pclk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .frame_tick  (frame_tick),
        .jump_btn    (jump_btn),
        .duck_btn    (duck_btn),
        .distance    (distance),
        .game_state  (game_state),
        .dino_y      (dino_y),
        .ducking     (ducking)
    );

    obstacle_field u_obstacles (
        .pclk        (pclk),
        .rst         (rst),
        .start_pulse (start_pulse),
        .frame_tick  (frame_tick),
        .speed       (speed),
        .game_state  (game_state),
        .obs_x       (obs_x),
        .obs_kind    (obs_kind),
        .obs_active  (obs_active),
        .retire      (retire)
    );

    // Pure combinational, sees registered positions
    hit_detect u_hit (
        .dino_y      (dino_y),
        .ducking     (ducking),
        .obs_x       (obs_x),
        .obs_kind    (obs_kind),
        .obs_active  (obs_active),
        .collision   (collision)
    );

endmodule

// ==== hit_detect.sv ====
`timescale 1ns/1ns
`include "dino_consts.svh"

module hit_detect (
    input  logic [`Y_W-1:0]         dino_y,
    input  logic                    ducking,
    input  logic signed [`X_W-1:0]  obs_x [0:2],
    input  dino_pkg::obs_kind_t     obs_kind [0:2],
    input  logic [2:0]              obs_active,
    output logic                    collision
);
    import dino_pkg::*;

    localparam logic signed [`X_W-1:0] DINO_LEFT = `X_W'(`DINO_X);
    localparam logic signed [`X_W-1:0] S_TOP     = `X_W'(`GROUND_Y - `CACTUS_S_H);
    localparam logic signed [`X_W-1:0] B_TOP     = `X_W'(`GROUND_Y - `CACTUS_B_H);
    localparam logic signed [`X_W-1:0] P_TOP     = `X_W'(`GROUND_Y - `PTERO_H - `PTERO_FLY_OFFSET);
    localparam logic signed [`X_W-1:0] P_BOT     = `X_W'(`GROUND_Y - `PTERO_FLY_OFFSET);

    logic signed [`X_W-1:0] dino_right;
    logic signed [`X_W-1:0] box_top;
    logic signed [`X_W-1:0] box_bot;

    function automatic logic signed [`X_W-1:0] obs_width(input obs_kind_t kind);
        case (kind)
            2'd0:    return `X_W'(`CACTUS_S_W);
            2'd1:    return `X_W'(`CACTUS_B_W);
            default: return `X_W'(`PTERO_W);
        endcase
    endfunction

    // Ducking widens the box and lowers its top
    assign dino_right = DINO_LEFT + (ducking ? `X_W'(`DINO_DUCK_W) : `X_W'(`DINO_W));
    assign box_top    = $signed(`X_W'(dino_y)) + (ducking ? `X_W'(`DUCK_BOX_CUT) : `X_W'(0));
    assign box_bot    = box_top + (ducking ? `X_W'(`DINO_DUCK_H - `DUCK_BOX_CUT)
                                           : `X_W'(`DINO_H));

    always_comb begin
        collision = 1'b0;
        for (int i = 0; i < 3; i++) begin
            if (obs_active[i] && (dino_right > obs_x[i]) &&
                (DINO_LEFT < obs_x[i] + obs_width(obs_kind[i]))) begin
                case (obs_kind[i])
                    2'd0: begin
                        if (box_bot > S_TOP) collision = 1'b1;
                    end
                    2'd1: begin
                        if (box_bot > B_TOP) collision = 1'b1;
                    end
                    default: begin
                        // Flying band, ducking under it is safe
                        if (box_bot > P_TOP && box_top < P_BOT) collision = 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// ==== obstacle_field.sv ====
`timescale 1ns/1ns
`include "dino_consts.svh"

module obstacle_field (
    input  logic                    pclk,
    input  logic                    rst,
    input  logic                    start_pulse,
    input  logic                    frame_tick,
    input  logic [6:0]              speed,
    input  dino_pkg::game_state_t   game_state,
    output logic signed [`X_W-1:0]  obs_x [0:2],
    output dino_pkg::obs_kind_t     obs_kind [0:2],
    output logic [2:0]              obs_active,
    output logic                    retire
);
    import dino_pkg::*;

    localparam logic signed [`X_W-1:0] X_SPAWN  = `X_W'(`SPAWN_X);
    localparam logic signed [`X_W-1:0] X_FIRST  = `X_W'(`FIRST_X);
    localparam logic signed [`X_W-1:0] X_RETIRE = `X_W'(`RETIRE_X);
    localparam logic signed [`X_W-1:0] X_GAP    = `X_W'(`SPAWN_X - `MIN_GAP);

    logic [9:0]              lfsr;
    logic [7:0]              spawn_off;      // Extra random gap to the next spawn
    logic [1:0]              last_idx;       // Slot spawned most recently
    logic [1:0]              next_idx;
    logic [2:0]              below;
    logic signed [`X_W-1:0]  spawn_thresh;
    logic signed [`X_W-1:0]  step;
    logic                    restart;

    assign next_idx     = (last_idx == 2'd2) ? 2'd0 : last_idx + 2'd1;
    assign spawn_thresh = X_GAP - $signed(`X_W'(spawn_off));
    assign step         = $signed(`X_W'(speed));
    assign restart      = (game_state == st_over) && start_pulse;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            below[i] = obs_active[i] && (obs_x[i] < X_RETIRE);
        end
    end

    assign retire = frame_tick & (|below);   // Feeds the score

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                obs_x[i]    <= X_SPAWN;
                obs_kind[i] <= '0;
            end
            obs_x[0]   <= X_FIRST;
            obs_active <= 3'b001;                // Slot 0 waits on screen
            last_idx   <= '0;
            spawn_off  <= '0;
            lfsr       <= 10'h001;
        end else begin
            lfsr <= {lfsr[8:0], lfsr[9] ^ lfsr[6]};  // x^10 + x^7 + 1
            if (restart) begin
                for (int i = 0; i < 3; i++) begin
                    obs_x[i]    <= X_SPAWN;
                    obs_kind[i] <= '0;
                end
                obs_x[0]   <= X_FIRST;
                obs_active <= 3'b001;
                last_idx   <= '0;
                spawn_off  <= '0;
            end else if (frame_tick) begin
                for (int i = 0; i < 3; i++) begin
                    if (obs_active[i]) begin
                        obs_x[i] <= obs_x[i] - step;
                        if (below[i]) begin
                            obs_active[i] <= 1'b0;
                        end
                    end
                end
                // Next slot in turn, once the gap behind the last one is wide enough
                if (obs_x[last_idx] < spawn_thresh && !obs_active[next_idx]) begin
                    obs_x[next_idx]      <= X_SPAWN;
                    obs_kind[next_idx]   <= obs_kind_t'(lfsr[9:8]);
                    obs_active[next_idx] <= 1'b1;
                    last_idx             <= next_idx;
                    spawn_off            <= lfsr[7:0];
                end
            end else if (game_state == st_idle && start_pulse) begin
                spawn_off <= lfsr[7:0];              // Vary the first gap
            end
        end
    end

endmodule

// ==== dino_physics.sv ====
`timescale 1ns/1ns
`include "dino_consts.svh"

module dino_physics (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  start_pulse,
    input  logic                  frame_tick,
    input  logic                  jump_btn,
    input  logic                  duck_btn,
    input  logic [19:0]           distance,
    input  dino_pkg::game_state_t game_state,
    output logic [`Y_W-1:0]       dino_y,
    output logic                  ducking
);
    import dino_pkg::*;

    localparam logic [`Y_W-1:0] STAND_Y = `Y_W'(`GROUND_Y - `DINO_H);
    localparam logic [`Y_W-1:0] DUCK_Y  = `Y_W'(`GROUND_Y - `DINO_DUCK_H);

    logic signed [`Y_W-1:0] dino_vel;   // Negative is upward
    logic signed [`Y_W+1:0] y_air;      // Position after one airborne step
    logic                   sensor_jump;
    logic                   sensor_duck;
    logic                   jump_req;
    logic                   duck_req;
    logic                   on_ground;
    logic                   restart;

    // Hand held over the sensor selects the action
    assign sensor_jump = (distance > 20'(`SENSE_JUMP_MIN)) && (distance < 20'(`SENSE_JUMP_MAX));
    assign sensor_duck = (distance > 20'd0) && (distance < 20'(`SENSE_DUCK_MAX));
    assign jump_req    = jump_btn | sensor_jump;
    assign duck_req    = duck_btn | sensor_duck;

    assign on_ground = (dino_y >= STAND_Y);
    assign restart   = (game_state == st_over) && start_pulse;
    assign y_air     = $signed({2'b00, dino_y}) + $signed({{2{dino_vel[`Y_W-1]}}, dino_vel});

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            dino_y   <= STAND_Y;
            dino_vel <= '0;
            ducking  <= 1'b0;
        end else if (restart) begin
            dino_y   <= STAND_Y;
            dino_vel <= '0;
            ducking  <= 1'b0;
        end else if (frame_tick) begin
            if (on_ground) begin
                if (jump_req) begin
                    dino_y   <= dino_y - `Y_W'(`JUMP_VEL);
                    dino_vel <= -$signed(`Y_W'(`JUMP_VEL));
                    ducking  <= 1'b0;
                end else if (duck_req) begin
                    dino_y   <= DUCK_Y;
                    dino_vel <= '0;
                    ducking  <= 1'b1;
                end else begin
                    dino_y   <= STAND_Y;
                    dino_vel <= '0;
                    ducking  <= 1'b0;
                end
            end else begin
                // Land on the ground line, never below it
                if (y_air >= $signed({2'b00, STAND_Y})) begin
                    dino_y <= STAND_Y;
                end else begin
                    dino_y <= y_air[`Y_W-1:0];
                end
                dino_vel <= dino_vel + (duck_req ? `Y_W'(`FAST_FALL) : `Y_W'(`GRAVITY));
                ducking  <= 1'b0;                          // No ducking mid-air
            end
        end
    end

endmodule

// ==== run_pacer.sv ====
`timescale 1ns/1ns
`include "dino_consts.svh"

module run_pacer (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  vsync,
    input  logic                  start_pulse,
    input  logic                  retire,
    input  dino_pkg::game_state_t game_state,
    output logic                  frame_tick,
    output logic [`SCORE_W-1:0]   score,
    output logic [6:0]            speed
);
    import dino_pkg::*;

    logic vsync_q;      // Last vsync sample
    logic vs_rise_q;    // One cycle per vsync rising edge

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            vsync_q   <= 1'b0;
            vs_rise_q <= 1'b0;
        end else begin
            vsync_q   <= vsync;
            vs_rise_q <= vsync & ~vsync_q;
        end
    end

    // Frames only advance while running
    assign frame_tick = vs_rise_q & (game_state == st_run);

    // One point per obstacle that leaves the screen
    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            score <= '0;
        end else if (game_state == st_over && start_pulse) begin
            score <= '0;
        end else if (retire) begin
            score <= score + 1'b1;
        end
    end

    assign speed = 7'(`BASE_SPEED) + 7'(score[`SCORE_W-1:4]);  // Faster every 16 points

endmodule

// ==== game_fsm.sv ====
`timescale 1ns/1ns

module game_fsm (
    input  logic                  pclk,
    input  logic                  rst,
    input  logic                  start_pulse,
    input  logic                  pause_pulse,
    input  logic                  collision,
    output dino_pkg::game_state_t game_state
);
    import dino_pkg::*;

    game_state_t state_nxt;

    always_comb begin
        state_nxt = game_state;
        case (game_state)
            st_idle: begin
                if (start_pulse) begin
                    state_nxt = st_run;
                end
            end
            st_run: begin
                // A hit wins over a pause request
                if (collision) begin
                    state_nxt = st_over;
                end else if (pause_pulse) begin
                    state_nxt = st_pause;
                end
            end
            st_pause: begin
                if (pause_pulse) begin
                    state_nxt = st_run;
                end
            end
            st_over: begin
                if (start_pulse) begin
                    state_nxt = st_idle;    // Data modules restore on this edge
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    always_ff @(posedge pclk or posedge rst) begin
        if (rst) begin
            game_state <= st_idle;
        end else begin
            game_state <= state_nxt;
        end
    end

endmodule

// ==== dino_pkg.sv ====
package dino_pkg;

    // Top level game mode
    typedef enum logic [1:0] {
        st_idle  = 2'd0,
        st_run   = 2'd1,
        st_over  = 2'd2,
        st_pause = 2'd3
    } game_state_t;

    // 0 small cactus, 1 big cactus, 2 and 3 pterodactyl
    typedef logic [1:0] obs_kind_t;

endpackage

// ==== dino_consts.svh ====
`ifndef DINO_CONSTS_SVH
`define DINO_CONSTS_SVH

// Screen geometry in pixels
`define GROUND_Y          350
`define DINO_X            160
`define DINO_W            36
`define DINO_H            40
`define DINO_DUCK_W       48
`define DINO_DUCK_H       38
`define DUCK_BOX_CUT      12     // Hit box top drop while ducking

// Obstacle boxes
`define CACTUS_S_W        14
`define CACTUS_S_H        30
`define CACTUS_B_W        20
`define CACTUS_B_H        40
`define PTERO_W           36
`define PTERO_H           34
`define PTERO_FLY_OFFSET  30     // Gap between ground and pterodactyl bottom

// Per-frame motion
`define JUMP_VEL          18
`define GRAVITY           1
`define FAST_FALL         3
`define BASE_SPEED        4

// Spawn and retire positions
`define SPAWN_X           640
`define FIRST_X           630
`define RETIRE_X          (-40)
`define MIN_GAP           300

// Distance sensor windows, bounds exclusive
`define SENSE_DUCK_MAX    10
`define SENSE_JUMP_MIN    20
`define SENSE_JUMP_MAX    50

// Register widths
`define X_W               13     // Signed, obstacles go off the left edge
`define Y_W               10
`define SCORE_W           10

`endif
